// File: vlog.f
+incdir+include
verilog/althea_bus_pkg.sv
verilog/reset_stretcher.sv
verilog/bus_protocol_slave.sv
verilog/halfword_ram.sv
verilog/althea_bus_top.sv
sim/althea_bus_properties.sv
sim/althea_bus_tb.sv

// File: run_sim.sh
#!/bin/sh
# Build the testbench with Verilator, run it and check the log.
# Exits non-zero when the build fails, the run aborts or a test fails.

cd "$(dirname "$0")" || exit 1

build_dir=obj_dir
log_file=sim.log

verilator --binary --timing --assert -Wno-fatal \
	-f vlog.f --top-module althea_bus_tb \
	-Mdir "$build_dir" -o althea_bus_sim
status=$?
if [ $status -ne 0 ]; then
	echo "build failed with status $status"
	exit 1
fi

"./$build_dir/althea_bus_sim" > "$log_file" 2>&1
status=$?
cat "$log_file"
if [ $status -ne 0 ]; then
	echo "simulation stopped with status $status"
	exit 1
fi

if grep -q "tests failed" "$log_file"; then
	echo "FAIL: see $log_file"
	exit 1
fi

echo "PASS"
exit 0

// File: sim/althea_bus_tb.sv
// host model drives 2 enable cycles and 2 idle cycles per beat
// inputs move 2 ns after the rising edge
// reads only touch written addresses
`timescale 1ns/10ps
`include "althea_bus_settings.svh"

module althea_bus_tb;

	localparam int max_cycles = 3000; // all tests take about 310 cycles
	localparam int hi = 2 * `BUS_WIDTH - 1;
	localparam int lo = `BUS_WIDTH - 1;

	logic clock50;
	logic reset;
	logic enable;
	logic read;
	logic register_select;
	althea_bus_pkg::bus_word_t bus_in;
	logic ack;
	althea_bus_pkg::bus_word_t bus_out;
	logic bus_oe;
	logic [7:0] leds;

	althea_bus_pkg::mem_word_t model [2 ** `BUS_WIDTH]; // last full write per address
	int seed;
	int error_count;
	int tests_run;
	int tests_failed;
	int cycle_count;
	int halves_taken; // data beats since the last address beat
	string current_test;

	althea_bus_top i_dut (
		.clock50(clock50),
		.reset(reset),
		.enable(enable),
		.read(read),
		.register_select(register_select),
		.bus_in(bus_in),
		.ack(ack),
		.bus_out(bus_out),
		.bus_oe(bus_oe),
		.leds(leds)
	);

	always #20 clock50 = ~clock50;

	always @(posedge clock50) begin
		cycle_count = cycle_count + 1;
		if (cycle_count >= max_cycles) begin
			$display("timeout: run did not finish within %0d cycles", max_cycles);
			$display("tests failed");
			$finish;
		end
	end

	task automatic check_half(input string name, input althea_bus_pkg::bus_word_t expected,
			input althea_bus_pkg::bus_word_t actual);
		assert (actual === expected) else begin
			$display("** Error %s: expected %h, actual %h", name, expected, actual);
			error_count++;
		end
	endtask

	// status LEDs and output enable in the second enable cycle of a beat
	task automatic check_outputs(input logic is_read, input logic select, input logic strobe);
		logic [7:0] expected;
		// ack, strobe, spare, reset, select, read, enable, internal reset
		expected = {1'b1, strobe, 1'b0, 1'b0, select, is_read, 1'b1, 1'b0};
		assert (leds === expected) else begin
			$display("** Error %s: leds expected %b, actual %b", current_test, expected, leds);
			error_count++;
		end
		assert (bus_oe === is_read) else begin
			$display("** Error %s: bus_oe expected %b, actual %b", current_test, is_read,
				bus_oe);
			error_count++;
		end
	endtask

	task automatic run_beat(input logic is_read, input logic select,
			input althea_bus_pkg::bus_word_t value, input logic strobe,
			output althea_bus_pkg::bus_word_t seen);
		int waited;
		waited = 0;
		enable = 1'b1;
		read = is_read;
		register_select = select;
		bus_in = value;
		do begin
			@(posedge clock50);
			#2;
			waited++;
		end while (!ack && waited < 3);
		assert (ack) else begin
			$display("slave gave no ack within %0d cycles of enable", waited);
			error_count++;
		end
		@(posedge clock50); // second enable cycle
		#2;
		seen = bus_out;
		check_outputs(is_read, select, strobe);
		enable = 1'b0;
		read = 1'b0;
		register_select = 1'b0;
		repeat (2) @(posedge clock50);
		#2;
	endtask

	task automatic address_beat(input althea_bus_pkg::bus_word_t addr);
		althea_bus_pkg::bus_word_t unused;
		halves_taken = 0;
		run_beat(1'b0, 1'b0, addr, 1'b0, unused);
	endtask

	// only the second half after an address beat writes the RAM
	task automatic data_beat(input althea_bus_pkg::bus_word_t half);
		althea_bus_pkg::bus_word_t unused;
		halves_taken++;
		run_beat(1'b0, 1'b1, half, halves_taken == 2, unused);
	endtask

	task automatic read_beat(output althea_bus_pkg::bus_word_t seen);
		run_beat(1'b1, 1'b0, '0, 1'b0, seen);
	endtask

	// model only changes once both halves went out
	task automatic write_word(input althea_bus_pkg::bus_word_t addr,
			input althea_bus_pkg::mem_word_t word);
		address_beat(addr);
		data_beat(word[hi:`BUS_WIDTH]);
		data_beat(word[lo:0]);
		model[addr] = word;
	endtask

	task automatic read_back(input string name, input althea_bus_pkg::bus_word_t addr);
		althea_bus_pkg::bus_word_t seen;
		address_beat(addr);
		read_beat(seen);
		check_half(name, model[addr][hi:`BUS_WIDTH], seen);
		read_beat(seen);
		check_half(name, model[addr][lo:0], seen);
	endtask

	task automatic finish_test(input string name, input int errors_before);
		tests_run++;
		if (error_count == errors_before) begin
			$display("test %s: ok", name);
		end else begin
			tests_failed++;
			$display("test %s: failed with %0d errors", name, error_count - errors_before);
		end
	endtask

	initial begin
		int errors_before;
		althea_bus_pkg::bus_word_t seen;
		althea_bus_pkg::bus_word_t addr_a;
		althea_bus_pkg::bus_word_t addrs [8];
		althea_bus_pkg::mem_word_t words [8];
		seed = 60;
		error_count = 0;
		tests_run = 0;
		tests_failed = 0;
		cycle_count = 0;
		halves_taken = 0;
		current_test = "reset_stretch";
		clock50 = 1'b0;
		reset = 1'b1;
		enable = 1'b1; // held high right through the stretch
		read = 1'b0;
		register_select = 1'b0;
		bus_in = '0;
		repeat (4) @(posedge clock50);
		#2;

		errors_before = error_count;
		// reset, enable and internal reset LEDs lit
		assert (leds === 8'b0001_0011) else begin
			$display("** Error reset_stretch: leds expected 00010011, actual %b", leds);
			error_count++;
		end
		reset = 1'b0;
		for (int i = 1; i <= 9; i++) begin
			@(posedge clock50);
			#2;
			assert (ack === 1'b0) else begin
				$display("** Error reset_stretch: expected 0, actual %b", ack);
				error_count++;
			end
		end
		@(posedge clock50);
		#2;
		assert (ack === 1'b1) else begin
			$display("** Error reset_stretch: expected 1, actual %b", ack);
			error_count++;
		end
		check_outputs(1'b0, 1'b0, 1'b0);
		enable = 1'b0;
		@(posedge clock50);
		#2;
		assert (ack === 1'b0) else begin
			$display("** Error reset_stretch: expected 0, actual %b", ack);
			error_count++;
		end
		repeat (5) @(posedge clock50); // rest of the 16 settle cycles
		#2;
		finish_test("reset_stretch", errors_before);

		errors_before = error_count;
		current_test = "write_read";
		write_word(8'h3c, 16'ha5c3);
		read_back("write_read", 8'h3c);
		finish_test("write_read", errors_before);

		errors_before = error_count;
		current_test = "random_traffic";
		for (int i = 0; i < 8; i++) begin
			addrs[i] = althea_bus_pkg::bus_word_t'($random(seed));
			words[i] = althea_bus_pkg::mem_word_t'($random(seed));
			write_word(addrs[i], words[i]);
		end
		for (int i = 7; i >= 0; i--) begin
			read_back("random_traffic", addrs[i]);
		end
		finish_test("random_traffic", errors_before);

		errors_before = error_count;
		current_test = "aborted_write";
		addr_a = addrs[0];
		address_beat(addr_a);
		data_beat(8'hee); // lone high half, dropped by the next address beat
		write_word(addr_a ^ 8'h5a, 16'h1234);
		read_back("aborted_write", addr_a ^ 8'h5a);
		read_back("aborted_write", addr_a);
		finish_test("aborted_write", errors_before);

		errors_before = error_count;
		current_test = "read_wrap";
		write_word(8'h81, 16'h6b2d);
		data_beat(8'h99); // third data beat must not write
		address_beat(8'h81);
		read_beat(seen);
		check_half("read_wrap", 8'h6b, seen);
		read_beat(seen);
		check_half("read_wrap", 8'h2d, seen);
		read_beat(seen);
		check_half("read_wrap", 8'h6b, seen); // wrapped to the high half
		finish_test("read_wrap", errors_before);

		$display("%0d tests run, %0d failed, %0d errors", tests_run, tests_failed, error_count);
		if (error_count == 0) begin
			$display("all tests passed");
		end else begin
			$display("tests failed");
		end
		$finish;
	end

endmodule

// File: sim/althea_bus_properties.sv
// protocol checks bound into althea_bus_top
// all checks are off while the external reset is high
`timescale 1ns/10ps

module althea_bus_properties (
	input logic clock50,
	input logic reset,
	input logic local_reset,
	input logic enable,
	input logic read,
	input logic ack,
	input logic bus_oe,
	input logic write_strobe
);

	// ack is enable delayed by one cycle once the slave is out of reset
	ack_follows_enable: assert property (@(posedge clock50) disable iff (reset)
		!$past(local_reset) |-> ack == $past(enable))
		else $error("ack did not follow enable by one cycle");

	quiet_in_reset: assert property (@(posedge clock50) disable iff (reset)
		local_reset |-> !ack && !write_strobe)
		else $error("ack or write strobe seen during internal reset");

	strobe_one_cycle: assert property (@(posedge clock50) disable iff (reset)
		write_strobe |=> !write_strobe)
		else $error("write strobe lasted more than one cycle");

	oe_matches_read: assert property (@(posedge clock50) disable iff (reset)
		bus_oe == read)
		else $error("bus output enable differs from read");

endmodule

bind althea_bus_top althea_bus_properties i_properties (
	.clock50(clock50),
	.reset(reset),
	.local_reset(local_reset),
	.enable(enable),
	.read(read),
	.ack(ack),
	.bus_oe(bus_oe),
	.write_strobe(write_strobe)
);

// File: verilog/althea_bus_top.sv
// host bus slave with its RAM; the tristate pad lives in a board wrapper,
// which drives the bus from bus_out while bus_oe is high
// leds: 7 ack, 6 write strobe, 4 reset, 3 register select, 2 read,
// 1 enable, 0 internal reset
`timescale 1ns/10ps

module althea_bus_top (
	input logic clock50,
	input logic reset,
	input logic enable,
	input logic read,
	input logic register_select,
	input althea_bus_pkg::bus_word_t bus_in,
	output logic ack,
	output althea_bus_pkg::bus_word_t bus_out,
	output logic bus_oe,
	output logic [7:0] leds
);

	logic local_reset;
	logic write_strobe;
	althea_bus_pkg::bus_word_t address;
	althea_bus_pkg::mem_word_t write_data;
	althea_bus_pkg::mem_word_t read_data;

	reset_stretcher i_reset_stretcher (
		.clock50(clock50),
		.reset(reset),
		.local_reset(local_reset)
	);

	bus_protocol_slave i_slave (
		.clock50(clock50),
		.local_reset(local_reset),
		.enable(enable),
		.read(read),
		.register_select(register_select),
		.bus_in(bus_in),
		.read_data(read_data),
		.ack(ack),
		.bus_out(bus_out),
		.bus_oe(bus_oe),
		.address(address),
		.write_data(write_data),
		.write_strobe(write_strobe)
	);

	halfword_ram i_ram (
		.clock50(clock50),
		.address(address),
		.write_data(write_data),
		.write_strobe(write_strobe),
		.read_data(read_data)
	);

	assign leds = {ack, write_strobe, 1'b0, reset, register_select, read, enable, local_reset};

endmodule

// File: verilog/halfword_ram.sv
// single clock RAM, 2**BUS_WIDTH words, read and write share one address
// read data is registered and shows the old word during a write
// contents power up undefined
`timescale 1ns/10ps
`include "althea_bus_settings.svh"

module halfword_ram (
	input logic clock50,
	input althea_bus_pkg::bus_word_t address,
	input althea_bus_pkg::mem_word_t write_data,
	input logic write_strobe,
	output althea_bus_pkg::mem_word_t read_data
);

	localparam int DEPTH = 2 ** `BUS_WIDTH;

	althea_bus_pkg::mem_word_t memory [DEPTH];

	always_ff @(posedge clock50) begin
		if (write_strobe) begin
			memory[address] <= write_data;
		end
	end

	// one cycle latency from the address
	always_ff @(posedge clock50) begin
		read_data <= memory[address];
	end

endmodule

// File: verilog/bus_protocol_slave.sv
// enable/ack strobe slave: address beat, two write halves, two read halves
// beat kind is taken from the first enable cycle; read and register_select
// must stay steady for the whole beat. no back-pressure toward the host
`timescale 1ns/10ps
`include "althea_bus_settings.svh"

module bus_protocol_slave (
	input logic clock50,
	input logic local_reset,
	input logic enable,
	input logic read,
	input logic register_select,
	input althea_bus_pkg::bus_word_t bus_in,
	input althea_bus_pkg::mem_word_t read_data,
	output logic ack,
	output althea_bus_pkg::bus_word_t bus_out,
	output logic bus_oe,
	output althea_bus_pkg::bus_word_t address,
	output althea_bus_pkg::mem_word_t write_data,
	output logic write_strobe
);

	althea_bus_pkg::write_phase_t write_phase;
	althea_bus_pkg::read_phase_t read_phase;
	althea_bus_pkg::bus_word_t write_high;
	althea_bus_pkg::bus_word_t write_low;
	althea_bus_pkg::bus_word_t read_high;
	althea_bus_pkg::bus_word_t read_low;
	logic enable_last;
	logic beat_start;
	logic address_beat;
	logic data_beat;
	logic read_beat;
	logic capture_high;
	logic capture_low;

	// a beat starts on the first sampled-high enable cycle
	assign beat_start = enable && !enable_last;
	assign address_beat = beat_start && !read && !register_select;
	assign data_beat = beat_start && !read && register_select;
	assign read_beat = beat_start && read;

	assign capture_high = data_beat && (write_phase == althea_bus_pkg::WRITE_WAIT_HIGH);
	assign capture_low = data_beat && (write_phase == althea_bus_pkg::WRITE_WAIT_LOW);

	assign read_high = read_data[2*`BUS_WIDTH-1:`BUS_WIDTH];
	assign read_low = read_data[`BUS_WIDTH-1:0];
	assign write_data = {write_high, write_low}; // high half came first

	assign bus_oe = read; // we drive whenever the host reads

	always_ff @(posedge clock50) begin
		if (local_reset) begin
			ack <= 1'b0;
			// enable held across reset must drop before it counts as a beat
			enable_last <= 1'b1;
		end else begin
			ack <= enable;
			enable_last <= enable;
		end
	end

	always_ff @(posedge clock50) begin
		if (local_reset) begin
			address <= '0;
		end else if (address_beat) begin
			address <= bus_in;
		end
	end

	// write halves
	always_ff @(posedge clock50) begin
		if (capture_high) begin
			write_high <= bus_in;
		end
		if (capture_low) begin
			write_low <= bus_in;
		end
	end

	always_ff @(posedge clock50) begin
		write_strobe <= 1'b0;
		if (local_reset) begin
			write_phase <= althea_bus_pkg::WRITE_WAIT_HIGH;
		end else if (address_beat) begin
			write_phase <= althea_bus_pkg::WRITE_WAIT_HIGH; // drops a half-written word
		end else begin
			case (write_phase)
				althea_bus_pkg::WRITE_WAIT_HIGH: begin
					if (capture_high) begin
						write_phase <= althea_bus_pkg::WRITE_HIGH_TAKEN;
					end
				end
				althea_bus_pkg::WRITE_HIGH_TAKEN: begin
					if (!enable) begin // rearm for the low half
						write_phase <= althea_bus_pkg::WRITE_WAIT_LOW;
					end
				end
				althea_bus_pkg::WRITE_WAIT_LOW: begin
					if (capture_low) begin
						write_phase <= althea_bus_pkg::WRITE_LOW_TAKEN;
					end
				end
				althea_bus_pkg::WRITE_LOW_TAKEN: begin
					write_strobe <= 1'b1; // one cycle after the low half
					write_phase <= althea_bus_pkg::WRITE_STROBE_DONE;
				end
				althea_bus_pkg::WRITE_STROBE_DONE: begin
					// extra data beats are ignored here
					write_phase <= althea_bus_pkg::WRITE_STROBE_DONE;
				end
				default: begin
					write_phase <= althea_bus_pkg::WRITE_WAIT_HIGH;
				end
			endcase
		end
	end

	// read halves alternate high, low, high...
	always_ff @(posedge clock50) begin
		if (local_reset) begin
			read_phase <= althea_bus_pkg::READ_SERVE_HIGH;
			bus_out <= '0;
		end else if (address_beat) begin
			read_phase <= althea_bus_pkg::READ_SERVE_HIGH;
		end else begin
			case (read_phase)
				althea_bus_pkg::READ_SERVE_HIGH: begin
					if (read_beat) begin
						bus_out <= read_high;
						read_phase <= althea_bus_pkg::READ_HIGH_SERVED;
					end
				end
				althea_bus_pkg::READ_HIGH_SERVED: begin
					if (!enable) begin
						read_phase <= althea_bus_pkg::READ_SERVE_LOW;
					end
				end
				althea_bus_pkg::READ_SERVE_LOW: begin
					if (read_beat) begin
						bus_out <= read_low;
						read_phase <= althea_bus_pkg::READ_LOW_SERVED;
					end
				end
				althea_bus_pkg::READ_LOW_SERVED: begin
					if (!enable) begin // wraps back to the high half
						read_phase <= althea_bus_pkg::READ_SERVE_HIGH;
					end
				end
				default: begin
					read_phase <= althea_bus_pkg::READ_SERVE_HIGH;
				end
			endcase
		end
	end

endmodule

// File: verilog/reset_stretcher.sv
// internal reset follows reset directly, then stays high until
// counter bit RESET_STRETCH_BITS sets (9 cycles with the default of 3)
`timescale 1ns/10ps
`include "althea_bus_settings.svh"

module reset_stretcher (
	input logic clock50,
	input logic reset,
	output logic local_reset
);

	logic [`RESET_STRETCH_BITS:0] stretch_count;
	logic stretch_active; // still counting after reset fell

	always_ff @(posedge clock50) begin
		if (reset) begin
			stretch_count <= '0;
			stretch_active <= 1'b1;
		end else if (stretch_active) begin
			if (stretch_count[`RESET_STRETCH_BITS]) begin
				stretch_active <= 1'b0;
			end
			stretch_count <= stretch_count + 1'b1;
		end
	end

	// high in the very first reset cycle too
	assign local_reset = reset || stretch_active;

endmodule

// File: verilog/althea_bus_pkg.sv
// types shared by the host bus slave and its RAM
// widths follow BUS_WIDTH from the settings header
`include "althea_bus_settings.svh"

package althea_bus_pkg;

	// one host bus halfword, also the RAM address
	typedef logic [`BUS_WIDTH-1:0] bus_word_t;

	// one RAM word, high half first on the bus
	typedef logic [2*`BUS_WIDTH-1:0] mem_word_t;

	typedef enum logic [2:0] {
		WRITE_WAIT_HIGH   = 3'd0,
		WRITE_HIGH_TAKEN  = 3'd1, // waits for enable low
		WRITE_WAIT_LOW    = 3'd2,
		WRITE_LOW_TAKEN   = 3'd3, // strobe goes out next
		WRITE_STROBE_DONE = 3'd4  // held until next address beat
	} write_phase_t;

	typedef enum logic [1:0] {
		READ_SERVE_HIGH = 2'd0,
		READ_HIGH_SERVED = 2'd1,
		READ_SERVE_LOW = 2'd2,
		READ_LOW_SERVED = 2'd3
	} read_phase_t;

endpackage

// File: include/althea_bus_settings.svh
// bus width also sets the RAM depth (2**BUS_WIDTH halfword pairs)
// stretch bit 3 holds the slave idle 9 cycles after reset falls
`ifndef ALTHEA_BUS_SETTINGS_SVH
`define ALTHEA_BUS_SETTINGS_SVH

`define BUS_WIDTH 8

// counter bit that ends the internal reset
`define RESET_STRETCH_BITS 3

`endif
